//--- sim.f
src/spmv_pkg.sv
src/lane_product_if.sv
src/group_sum_if.sv
src/lane_multiplier.sv
src/segment_adder.sv
src/result_packer.sv
src/spmv_reduce_top.sv
testbench/spmv_reduce_props.sv
testbench/spmv_reduce_tb.sv

//--- src/group_sum_if.sv
// group sum bus
`timescale 1ns/1ps

interface group_sum_if import spmv_pkg::*; ();

    // totals sit at the lane that closes each group, zero elsewhere
    sum_t       sums [LANES];
    lane_mask_t group_end;
    logic       valid;

    modport src (
        output sums,
        output group_end,
        output valid
    );

    modport dst (
        input sums,
        input group_end,
        input valid
    );

endinterface

//--- src/lane_multiplier.sv
// lane multiplier stage
`timescale 1ns/1ps

module lane_multiplier import spmv_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic [ELEMS_W-1:0] mat_elems,
    input  logic [ELEMS_W-1:0] vec_elems,
    input  pattern_t           row_pattern,
    lane_product_if.src        prod_bus
);

    elem_t mat [LANES];
    elem_t vec [LANES];
    prod_t prod [LANES];

    // lane 0 sits in the top byte of each bus
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            mat[i]  = mat_elems[ELEMS_W-1-i*ELEM_W -: ELEM_W];
            vec[i]  = vec_elems[ELEMS_W-1-i*ELEM_W -: ELEM_W];
            prod[i] = mat[i] * vec[i];
        end
    end

    // products travel with their pattern
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prod_bus.valid    <= 1'b0;
            prod_bus.pattern  <= '0;
            prod_bus.products <= '{default: '0};
        end else begin
            prod_bus.valid <= in_valid;
            if (in_valid) begin
                prod_bus.pattern  <= row_pattern;
                prod_bus.products <= prod;
            end
        end
    end

endmodule

//--- src/lane_product_if.sv
// lane product bus
`timescale 1ns/1ps

interface lane_product_if import spmv_pkg::*; ();

    // registered products, lane 0 first
    prod_t    products [LANES];
    pattern_t pattern;
    logic     valid;

    modport src (
        output products,
        output pattern,
        output valid
    );

    modport dst (
        input products,
        input pattern,
        input valid
    );

endinterface

//--- src/result_packer.sv
// result slot packer
`timescale 1ns/1ps

module result_packer import spmv_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    group_sum_if.dst          sum_bus,
    output logic [SUMS_W-1:0] row_sums,
    output logic              out_valid
);

    localparam int SLOT_W = $clog2(LANES);

    // one spare bit so the count can reach LANES
    logic [SLOT_W:0]   slot_idx;
    sum_t              slot_val [LANES];
    logic [SUMS_W-1:0] row_next;

    // compact group totals into slots in lane order
    always_comb begin
        slot_idx = '0;
        slot_val = '{default: '0};
        for (int i = 0; i < LANES; i++) begin
            if (sum_bus.group_end[i]) begin
                slot_val[slot_idx[SLOT_W-1:0]] = sum_bus.sums[i];
                slot_idx = slot_idx + 1'b1;
            end
        end
    end

    // slot 0 lands in the top bits
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            row_next[SUMS_W-1-i*SUM_W -: SUM_W] = slot_val[i];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
            row_sums  <= '0;
        end else begin
            out_valid <= sum_bus.valid;
            if (sum_bus.valid) begin
                row_sums <= row_next;
            end
        end
    end

endmodule

//--- src/segment_adder.sv
// segmented adder tree
`timescale 1ns/1ps

module segment_adder import spmv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    lane_product_if.dst prod_bus,
    group_sum_if.src    sum_bus
);

    // first level, pair sums
    sum_t       lvl1_next [LANES];
    sum_t       lvl1_val [LANES];
    pattern_t   lvl1_pattern;
    logic       lvl1_valid;

    // second level, merge across the middle gap
    sum_t       lvl2_next [LANES];
    sum_t       tail;
    lane_mask_t group_end_next;

    // map table for gaps 0 and 2
    // an unbroken pair leaves its sum on the upper lane
    always_comb begin
        for (int p = 0; p < LANES / 2; p++) begin
            if (prod_bus.pattern[2*p]) begin
                lvl1_next[2*p]   = sum_t'(prod_bus.products[2*p]);
                lvl1_next[2*p+1] = sum_t'(prod_bus.products[2*p+1]);
            end else begin
                lvl1_next[2*p]   = '0;
                lvl1_next[2*p+1] = sum_t'(prod_bus.products[2*p])
                                 + sum_t'(prod_bus.products[2*p+1]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lvl1_valid   <= 1'b0;
            lvl1_pattern <= '0;
            lvl1_val     <= '{default: '0};
        end else begin
            lvl1_valid <= prod_bus.valid;
            if (prod_bus.valid) begin
                lvl1_pattern <= prod_bus.pattern;
                lvl1_val     <= lvl1_next;
            end
        end
    end

    // lane 3 always closes the last group
    assign group_end_next = {1'b1, lvl1_pattern};

    // map table for gap 1
    // without a middle boundary the left tail joins the first group end on the right
    always_comb begin
        tail         = lvl1_pattern[1] ? '0 : lvl1_val[1];
        lvl2_next[0] = lvl1_val[0];
        lvl2_next[1] = lvl1_pattern[1] ? lvl1_val[1] : '0;
        lvl2_next[2] = lvl1_pattern[2] ? lvl1_val[2] + tail : lvl1_val[2];
        lvl2_next[3] = lvl1_pattern[2] ? lvl1_val[3] : lvl1_val[3] + tail;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sum_bus.valid     <= 1'b0;
            sum_bus.group_end <= '0;
            sum_bus.sums      <= '{default: '0};
        end else begin
            sum_bus.valid <= lvl1_valid;
            if (lvl1_valid) begin
                sum_bus.group_end <= group_end_next;
                sum_bus.sums      <= lvl2_next;
            end
        end
    end

endmodule

//--- src/spmv_pkg.sv
// sparse reduction types
package spmv_pkg;

    // lane count is fixed by the 3-bit row pattern
    localparam int LANES = 4;

    localparam int ELEM_W = 8;
    localparam int PROD_W = 2 * ELEM_W;

    // two extra bits so four products never overflow
    localparam int SUM_W = PROD_W + 2;

    // packed operand and result buses
    localparam int ELEMS_W = LANES * ELEM_W;
    localparam int SUMS_W  = LANES * SUM_W;

    // signed matrix or vector element
    typedef logic signed [ELEM_W-1:0] elem_t;

    // signed lane product
    typedef logic signed [PROD_W-1:0] prod_t;

    // signed group total
    typedef logic signed [SUM_W-1:0] sum_t;

    // bit i set means a row boundary between lane i and lane i+1
    typedef logic [LANES-2:0] pattern_t;

    // one bit per lane
    typedef logic [LANES-1:0] lane_mask_t;

endpackage

//--- src/spmv_reduce_top.sv
// segmented reduction top
`timescale 1ns/1ps

module spmv_reduce_top import spmv_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic [ELEMS_W-1:0] mat_elems,
    input  logic [ELEMS_W-1:0] vec_elems,
    input  pattern_t           row_pattern,
    output logic [SUMS_W-1:0]  row_sums,
    output logic               out_valid
);

    // multiplier to adder
    lane_product_if prod_bus ();

    // adder to packer
    group_sum_if sum_bus ();

    lane_multiplier i_mult (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .mat_elems   (mat_elems),
        .vec_elems   (vec_elems),
        .row_pattern (row_pattern),
        .prod_bus    (prod_bus.src)
    );

    segment_adder i_adder (
        .clk      (clk),
        .rst      (rst),
        .prod_bus (prod_bus.dst),
        .sum_bus  (sum_bus.src)
    );

    result_packer i_packer (
        .clk       (clk),
        .rst       (rst),
        .sum_bus   (sum_bus.dst),
        .row_sums  (row_sums),
        .out_valid (out_valid)
    );

endmodule

//--- testbench/spmv_reduce_props.sv
// reduction port assertions
`timescale 1ns/1ps

module spmv_reduce_props import spmv_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              in_valid,
    input pattern_t          row_pattern,
    input logic [SUMS_W-1:0] row_sums,
    input logic              out_valid
);

    // register stages from in_valid to out_valid
    localparam int LATENCY = 4;

    // failed assertion count
    int fail_count = 0;

    // quiet output through reset and the edge after it
    assert property (@(posedge clk) (!rst || $past(!rst)) |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during or right after reset");
        end

    // edges with no history yet count as idle
    assert property (@(posedge clk) disable iff (!rst)
        out_valid == ($past(in_valid, LATENCY) === 1'b1))
        else begin
            fail_count++;
            $error("out_valid does not follow in_valid by the pipeline latency");
        end

    // slot k is unused when fewer than k boundaries were set
    for (genvar k = 1; k < LANES; k++) begin : g_unused_slot
        assert property (@(posedge clk) disable iff (!rst)
            (out_valid && ($countones($past(row_pattern, LATENCY)) < k))
            |-> (row_sums[SUMS_W-1-k*SUM_W -: SUM_W] == '0))
            else begin
                fail_count++;
                $error("unused output slot %0d is not zero", k);
            end
    end

endmodule

bind spmv_reduce_top spmv_reduce_props i_props (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .row_pattern (row_pattern),
    .row_sums    (row_sums),
    .out_valid   (out_valid)
);

//--- testbench/spmv_reduce_tb.sv
// segmented reduction testbench
`timescale 1ns/1ps

module spmv_reduce_tb import spmv_pkg::*; ();

    // register stages from input to output
    localparam int LATENCY     = 4;
    localparam int STALL_LIMIT = 20;
    localparam int DRAIN_LIMIT = 50;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic [ELEMS_W-1:0] mat_elems;
    logic [ELEMS_W-1:0] vec_elems;
    pattern_t           row_pattern;
    logic [SUMS_W-1:0]  row_sums;
    logic               out_valid;

    integer seed = 32'hf45523cc;
    int     edge_count;
    int     value_errors;
    int     other_errors;
    int     stall_cycles;

    // items in flight, oldest first
    logic [ELEMS_W-1:0] sent_mat [$];
    logic [ELEMS_W-1:0] sent_vec [$];
    pattern_t           sent_pat [$];
    int                 sent_edge [$];

    spmv_reduce_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .mat_elems   (mat_elems),
        .vec_elems   (vec_elems),
        .row_pattern (row_pattern),
        .row_sums    (row_sums),
        .out_valid   (out_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // group sums in lane order, slot 0 on top, unused slots zero
    function automatic logic [SUMS_W-1:0] ref_row_sums(
        input logic [ELEMS_W-1:0] mat,
        input logic [ELEMS_W-1:0] vec,
        input pattern_t           pat
    );
        logic [SUMS_W-1:0] result;
        lane_mask_t        closes;
        integer            acc;
        integer            a;
        integer            b;
        int                slot;
        result = '0;
        closes = {1'b1, pat};
        acc    = 0;
        slot   = 0;
        for (int lane = 0; lane < LANES; lane++) begin
            a   = $signed(mat[ELEMS_W-1-lane*ELEM_W -: ELEM_W]);
            b   = $signed(vec[ELEMS_W-1-lane*ELEM_W -: ELEM_W]);
            acc = acc + a * b;
            if (closes[lane]) begin
                result[SUMS_W-1-slot*SUM_W -: SUM_W] = acc[SUM_W-1:0];
                slot = slot + 1;
                acc  = 0;
            end
        end
        return result;
    endfunction

    task automatic check_value(
        input string             name,
        input logic [SUMS_W-1:0] expected,
        input logic [SUMS_W-1:0] actual
    );
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic send_item(
        input logic [ELEMS_W-1:0] mat,
        input logic [ELEMS_W-1:0] vec,
        input pattern_t           pat
    );
        @(posedge clk);
        in_valid    <= 1'b1;
        mat_elems   <= mat;
        vec_elems   <= vec;
        row_pattern <= pat;
        sent_mat.push_back(mat);
        sent_vec.push_back(vec);
        sent_pat.push_back(pat);
        sent_edge.push_back(edge_count + 1);
    endtask

    // idle cycle with junk on the data lines
    task automatic drive_idle();
        @(posedge clk);
        in_valid    <= 1'b0;
        mat_elems   <= $random(seed);
        vec_elems   <= $random(seed);
        row_pattern <= pattern_t'($random(seed));
    endtask

    // compare each result against the oldest outstanding item
    always @(negedge clk) begin
        if (out_valid) begin
            stall_cycles = 0;
            if (sent_mat.size() == 0) begin
                $display("ERROR: out_valid high with no item outstanding");
                other_errors++;
            end else begin
                check_value("row_sums", ref_row_sums(sent_mat.pop_front(),
                    sent_vec.pop_front(), sent_pat.pop_front()), row_sums);
                check_value("out_valid edge", sent_edge.pop_front() + LATENCY, edge_count);
            end
        end else if (sent_mat.size() > 0) begin
            stall_cycles++;
            if (stall_cycles == STALL_LIMIT) begin
                $display("ERROR: timeout, no out_valid for %0d cycles with items outstanding",
                    STALL_LIMIT);
                other_errors++;
            end
        end else begin
            stall_cycles = 0;
        end
    end

    initial begin
        int                 wait_cycles;
        int                 prop_errors;
        logic [ELEMS_W-1:0] mat;
        logic [ELEMS_W-1:0] vec;
        clk          = 1'b0;
        rst          = 1'b0;
        in_valid     = 1'b0;
        mat_elems    = '0;
        vec_elems    = '0;
        row_pattern  = '0;
        edge_count   = 0;
        value_errors = 0;
        other_errors = 0;
        stall_cycles = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;

        // nothing comes out before the first item
        repeat (3) begin
            @(negedge clk);
            check_value("out_valid", '0, out_valid);
            check_value("row_sums", '0, row_sums);
        end

        // single row with extreme operands
        send_item(32'h80808080, 32'h80808080, 3'b000);
        send_item(32'h7f7f7f7f, 32'h80808080, 3'b000);
        send_item(32'h7f807f80, 32'h7f7f8080, 3'b000);
        send_item(32'h7f7f7f7f, 32'h7f7f7f7f, 3'b000);
        drive_idle();

        for (int p = 0; p < 8; p++) begin
            repeat (4) begin
                mat = $random(seed);
                vec = $random(seed);
                send_item(mat, vec, pattern_t'(p));
            end
            drive_idle();
        end

        // back to back
        repeat (64) begin
            mat = $random(seed);
            vec = $random(seed);
            send_item(mat, vec, pattern_t'($random(seed)));
        end

        // random gaps
        repeat (64) begin
            mat = $random(seed);
            vec = $random(seed);
            if (($random(seed) & 1) != 0) begin
                send_item(mat, vec, pattern_t'($random(seed)));
            end else begin
                drive_idle();
            end
        end
        drive_idle();

        wait_cycles = 0;
        while (sent_mat.size() > 0 && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (sent_mat.size() > 0) begin
            $display("ERROR: %0d items still outstanding at the end", sent_mat.size());
            other_errors++;
        end
        // catch stray out_valid pulses
        repeat (8) @(negedge clk);

        prop_errors = i_dut.i_props.fail_count;
        $display("value errors: %0d, other errors: %0d, assertion errors: %0d",
            value_errors, other_errors, prop_errors);
        if (value_errors == 0 && other_errors == 0 && prop_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
